// ==== files.f ====
+incdir+verif
logic/bp_pkg.sv
logic/rv32_pkg.sv
logic/bp_update_if.sv
logic/pht.sv
logic/global_history.sv
logic/btb.sv
logic/tournament_chooser.sv
logic/bp_top.sv
verif/bp_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bp_tb -f files.f -o Vbp_tb
./obj_dir/Vbp_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== verif/bp_tb_tasks.svh ====
task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
	input logic [WORD_BITS-1:0] exp);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		stop_on_failure();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		stop_on_failure();
	end
endtask

task automatic check_ghr(input string name, input logic [GHR_BITS-1:0] got,
	input logic [GHR_BITS-1:0] exp);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		stop_on_failure();
	end
endtask

// late counts the cycles past the one right after the lookup edge
task automatic wait_for_prediction(output int late);
	late = 0;
	while (pred_valid_o !== 1'b1) begin
		if (late == WAIT_LIMIT) begin
			$display("timeout: pred_valid_o did not rise after a lookup");
			stop_on_failure();
		end
		@(posedge clk);
		#DRIVE_DELAY;
		late++;
	end
endtask

// the prediction belongs to the cycle right after the lookup edge
task automatic check_on_time(input int late);
	if (late != 0) begin
		$display("prediction for a lookup arrived %0d cycles late", late);
		stop_on_failure();
	end
endtask

// a lookup gives a single cycle of pred_valid_o
task automatic check_valid_drops();
	@(posedge clk);
	#DRIVE_DELAY;
	check_bit("pred_valid_o", pred_valid_o, 1'b0);
endtask

// grab the prediction outputs and compare against the model
task automatic capture_and_check(input logic [WORD_BITS-1:0] pc);
	logic                 exp_taken;
	logic                 exp_gshare;
	logic [WORD_BITS-1:0] exp_next;
	logic [GHR_BITS-1:0]  exp_ghr;
	model_predict(pc, exp_taken, exp_next, exp_gshare, exp_ghr);
	got_taken  = pred_taken_o;
	got_next   = pred_next_pc_o;
	got_gshare = pred_gshare_o;
	got_ghr    = pred_ghr_o;
	check_bit("pred_taken_o", got_taken, exp_taken);
	check_word("pred_next_pc_o", got_next, exp_next);
	check_bit("pred_gshare_o", got_gshare, exp_gshare);
	check_ghr("pred_ghr_o", got_ghr, exp_ghr);
endtask

// all drive tasks start and end 2 ns after a rising edge
task automatic lookup(input logic [WORD_BITS-1:0] pc);
	int late;
	lookup_i    = 1'b1;
	lookup_pc_i = pc;
	@(posedge clk);
	#DRIVE_DELAY;
	lookup_i = 1'b0;
	wait_for_prediction(late);
	check_on_time(late);
	capture_and_check(pc);
	check_valid_drops();
endtask

// two lookups on consecutive cycles with their results in order
task automatic lookup_pair(input logic [WORD_BITS-1:0] pc_a,
	input logic [WORD_BITS-1:0] pc_b);
	int late;
	lookup_i    = 1'b1;
	lookup_pc_i = pc_a;
	@(posedge clk);
	#DRIVE_DELAY;
	lookup_pc_i = pc_b;
	wait_for_prediction(late);
	check_on_time(late);
	capture_and_check(pc_a);
	@(posedge clk);
	#DRIVE_DELAY;
	lookup_i = 1'b0;
	wait_for_prediction(late);
	check_on_time(late);
	capture_and_check(pc_b);
	check_valid_drops();
endtask

task automatic resolve(input logic [WORD_BITS-1:0] pc, input logic taken,
	input logic [WORD_BITS-1:0] target, input logic [GHR_BITS-1:0] ghr,
	input logic used_gshare, input logic pred_taken);
	resolve_i            = 1'b1;
	resolve_pc_i         = pc;
	resolve_taken_i      = taken;
	resolve_target_i     = target;
	resolve_ghr_i        = ghr;
	resolve_gshare_i     = used_gshare;
	resolve_pred_taken_i = pred_taken;
	@(posedge clk);
	#DRIVE_DELAY;
	resolve_i = 1'b0;
	model_train(pc, taken, target, ghr, used_gshare, pred_taken);
endtask

// ==== verif/bp_tb.sv ====
`timescale 1ns/1ps

module bp_tb import rv32_pkg::*, bp_pkg::*;;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int WAIT_LIMIT  = 20;

	// A and C share table and BTB index but not the tag
	localparam logic [WORD_BITS-1:0] ADDR_A   = 32'h0000_1040;
	localparam logic [WORD_BITS-1:0] TARGET_A = 32'h0000_2000;
	localparam logic [WORD_BITS-1:0] ADDR_B   = 32'h0000_3a00;
	localparam logic [WORD_BITS-1:0] TARGET_B = 32'h0000_0400;
	localparam logic [WORD_BITS-1:0] ADDR_C   = 32'h0000_2040;

	logic                 clk;
	logic                 rst_i;
	logic                 lookup_i;
	logic [WORD_BITS-1:0] lookup_pc_i;
	logic                 pred_valid_o;
	logic                 pred_taken_o;
	logic [WORD_BITS-1:0] pred_next_pc_o;
	logic [GHR_BITS-1:0]  pred_ghr_o;
	logic                 pred_gshare_o;
	logic                 resolve_i;
	logic [WORD_BITS-1:0] resolve_pc_i;
	logic                 resolve_taken_i;
	logic [WORD_BITS-1:0] resolve_target_i;
	logic [GHR_BITS-1:0]  resolve_ghr_i;
	logic                 resolve_gshare_i;
	logic                 resolve_pred_taken_i;

	// last observed prediction
	logic                 got_taken;
	logic                 got_gshare;
	logic [WORD_BITS-1:0] got_next;
	logic [GHR_BITS-1:0]  got_ghr;

	// reference model state
	logic [CTR_BITS-1:0]     m_local [PHT_ENTRIES];
	logic [CTR_BITS-1:0]     m_gshare [PHT_ENTRIES];
	logic [CTR_BITS-1:0]     m_choice [PHT_ENTRIES];
	logic [BTB_ENTRIES-1:0]  m_btb_valid;
	logic [BTB_TAG_BITS-1:0] m_btb_tag [BTB_ENTRIES];
	logic [WORD_BITS-1:0]    m_btb_target [BTB_ENTRIES];
	logic [GHR_BITS-1:0]     m_ghr;
	integer                  seed = 42336;

	bp_top u_bp_top (
		.clk                  (clk),
		.rst_i                (rst_i),
		.lookup_i             (lookup_i),
		.lookup_pc_i          (lookup_pc_i),
		.pred_valid_o         (pred_valid_o),
		.pred_taken_o         (pred_taken_o),
		.pred_next_pc_o       (pred_next_pc_o),
		.pred_ghr_o           (pred_ghr_o),
		.pred_gshare_o        (pred_gshare_o),
		.resolve_i            (resolve_i),
		.resolve_pc_i         (resolve_pc_i),
		.resolve_taken_i      (resolve_taken_i),
		.resolve_target_i     (resolve_target_i),
		.resolve_ghr_i        (resolve_ghr_i),
		.resolve_gshare_i     (resolve_gshare_i),
		.resolve_pred_taken_i (resolve_pred_taken_i)
	);

	`include "bp_tb_tasks.svh"

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [CTR_BITS-1:0] saturating_count(input logic [CTR_BITS-1:0] ctr,
		input logic up);
		logic [CTR_BITS-1:0] result;
		result = ctr;
		if (up && ctr != 2'd3) begin
			result = ctr + 2'd1;
		end else if (!up && ctr != 2'd0) begin
			result = ctr - 2'd1;
		end
		return result;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < PHT_ENTRIES; i++) begin
			m_local[i]  = 2'd1;
			m_gshare[i] = 2'd1;
			m_choice[i] = 2'd1;
		end
		m_btb_valid = '0;
		m_ghr       = '0;
	endtask

	// table index pc[11:2], BTB index pc[7:2], tag pc[31:8]
	task automatic model_predict(input logic [WORD_BITS-1:0] pc, output logic taken,
		output logic [WORD_BITS-1:0] next_pc, output logic use_gshare,
		output logic [GHR_BITS-1:0] ghr);
		logic [PHT_INDEX_BITS-1:0] lidx;
		logic [BTB_INDEX_BITS-1:0] bidx;
		logic [CTR_BITS-1:0]       ctr;
		logic                      hit;
		lidx       = pc[11:2];
		bidx       = pc[7:2];
		use_gshare = m_choice[lidx][1];
		ctr        = use_gshare ? m_gshare[m_ghr ^ lidx] : m_local[lidx];
		hit        = m_btb_valid[bidx] && (m_btb_tag[bidx] == pc[31:8]);
		taken      = ctr[1] && hit;
		next_pc    = taken ? m_btb_target[bidx] : pc + 32'd4;
		ghr        = m_ghr;
	endtask

	task automatic model_train(input logic [WORD_BITS-1:0] pc, input logic taken,
		input logic [WORD_BITS-1:0] target, input logic [GHR_BITS-1:0] ghr,
		input logic used_gshare, input logic pred_taken);
		logic [PHT_INDEX_BITS-1:0] lidx;
		logic [PHT_INDEX_BITS-1:0] gidx;
		logic [BTB_INDEX_BITS-1:0] bidx;
		logic                      toward;
		lidx           = pc[11:2];
		gidx           = ghr ^ lidx;
		bidx           = pc[7:2];
		m_local[lidx]  = saturating_count(m_local[lidx], taken);
		m_gshare[gidx] = saturating_count(m_gshare[gidx], taken);
		toward         = (pred_taken == taken) ? used_gshare : !used_gshare;
		m_choice[lidx] = saturating_count(m_choice[lidx], toward);
		if (taken) begin
			m_btb_valid[bidx]  = 1'b1;
			m_btb_tag[bidx]    = pc[31:8];
			m_btb_target[bidx] = target;
		end
		m_ghr = {m_ghr[GHR_BITS-2:0], taken};
	endtask

	task automatic test_reset_state();
		logic [WORD_BITS-1:0] pc;
		for (int i = 0; i < 4; i++) begin
			pc      = $random(seed);
			pc[1:0] = 2'b00;
			lookup(pc);
			check_bit("pred_taken_o", got_taken, 1'b0);
			check_word("pred_next_pc_o", got_next, pc + 32'd4);
			check_bit("pred_gshare_o", got_gshare, 1'b0);
			check_ghr("pred_ghr_o", got_ghr, '0);
		end
	endtask

	task automatic test_taken_then_not_taken();
		// a correct local guess keeps the chooser on local
		resolve(ADDR_A, 1'b1, TARGET_A, m_ghr, 1'b0, 1'b1);
		lookup(ADDR_A);
		check_bit("pred_taken_o", got_taken, 1'b1);
		check_word("pred_next_pc_o", got_next, TARGET_A);
		repeat (2) resolve(ADDR_A, 1'b0, TARGET_A, m_ghr, 1'b0, 1'b0);
		lookup(ADDR_A);
		check_bit("pred_taken_o", got_taken, 1'b0);
		check_word("pred_next_pc_o", got_next, ADDR_A + 32'd4);
	endtask

	task automatic test_history_random();
		logic [WORD_BITS-1:0] pc;
		logic [WORD_BITS-1:0] target;
		logic [31:0]          r;
		logic [GHR_BITS-1:0]  exp_ghr;
		for (int i = 0; i < 12; i++) begin
			pc          = $random(seed);
			pc[1:0]     = 2'b00;
			target      = $random(seed);
			target[1:0] = 2'b00;
			r           = $random(seed);
			resolve(pc, r[0], target, m_ghr, r[1], r[2]);
		end
		exp_ghr = m_ghr;
		pc      = $random(seed);
		pc[1:0] = 2'b00;
		lookup(pc);
		check_ghr("pred_ghr_o", got_ghr, exp_ghr);
	endtask

	task automatic test_chooser_switch();
		// local was used and guessed wrong twice
		repeat (2) resolve(ADDR_B, 1'b1, TARGET_B, m_ghr, 1'b0, 1'b0);
		lookup(ADDR_B);
		check_bit("pred_gshare_o", got_gshare, 1'b1);
		check_bit("pred_taken_o", got_taken, m_gshare[m_ghr ^ ADDR_B[11:2]][1]);
	endtask

	task automatic test_alias_and_order();
		repeat (2) resolve(ADDR_A, 1'b1, TARGET_A, m_ghr, 1'b0, 1'b1);
		lookup_pair(ADDR_A, ADDR_C);
		check_bit("pred_taken_o", got_taken, 1'b0);
		check_word("pred_next_pc_o", got_next, ADDR_C + 32'd4);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_i                = 1'b1;
		lookup_i             = 1'b0;
		lookup_pc_i          = '0;
		resolve_i            = 1'b0;
		resolve_pc_i         = '0;
		resolve_taken_i      = 1'b0;
		resolve_target_i     = '0;
		resolve_ghr_i        = '0;
		resolve_gshare_i     = 1'b0;
		resolve_pred_taken_i = 1'b0;
		model_reset();
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		rst_i = 1'b0;
		test_reset_state();
		test_taken_then_not_taken();
		test_history_random();
		test_chooser_switch();
		test_alias_and_order();
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== logic/bp_top.sv ====
`timescale 1ns/1ps

module bp_top import rv32_pkg::*, bp_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,

	// lookup from fetch
	input  logic                 lookup_i,
	input  logic [WORD_BITS-1:0] lookup_pc_i,

	// prediction, one cycle after the lookup
	output logic                 pred_valid_o,
	output logic                 pred_taken_o,
	output logic [WORD_BITS-1:0] pred_next_pc_o,
	output logic [GHR_BITS-1:0]  pred_ghr_o,
	output logic                 pred_gshare_o,

	// resolution from the pipeline with the lookup snapshot
	input  logic                 resolve_i,
	input  logic [WORD_BITS-1:0] resolve_pc_i,
	input  logic                 resolve_taken_i,
	input  logic [WORD_BITS-1:0] resolve_target_i,
	input  logic [GHR_BITS-1:0]  resolve_ghr_i,
	input  logic                 resolve_gshare_i,
	input  logic                 resolve_pred_taken_i
);

	fetch_addr_u               lookup_addr;

	logic [CTR_BITS-1:0]       local_ctr;
	logic [CTR_BITS-1:0]       gshare_ctr;
	logic [PHT_INDEX_BITS-1:0] gshare_rd_index;
	logic [PHT_INDEX_BITS-1:0] gshare_wr_index;
	logic                      btb_hit;
	logic [WORD_BITS-1:0]      btb_target;

	bp_update_if upd_if ();

	assign lookup_addr = lookup_pc_i;

	assign upd_if.valid       = resolve_i;
	assign upd_if.pc          = resolve_pc_i;
	assign upd_if.taken       = resolve_taken_i;
	assign upd_if.target      = resolve_target_i;
	assign upd_if.ghr         = resolve_ghr_i;
	assign upd_if.used_gshare = resolve_gshare_i;
	assign upd_if.pred_taken  = resolve_pred_taken_i;

	// per-address counters
	pht u_local_pht (
		.clk        (clk),
		.rst_i      (rst_i),
		.rd_en_i    (lookup_i),
		.rd_index_i (lookup_addr.tbl.index),
		.wr_index_i (upd_if.pc.tbl.index),
		.upd        (upd_if.trainer),
		.ctr_o      (local_ctr)
	);

	// history-hashed counters
	pht u_gshare_pht (
		.clk        (clk),
		.rst_i      (rst_i),
		.rd_en_i    (lookup_i),
		.rd_index_i (gshare_rd_index),
		.wr_index_i (gshare_wr_index),
		.upd        (upd_if.trainer),
		.ctr_o      (gshare_ctr)
	);

	global_history u_global_history (
		.clk               (clk),
		.rst_i             (rst_i),
		.lookup_i          (lookup_i),
		.lookup_pc_i       (lookup_addr),
		.upd               (upd_if.trainer),
		.gshare_rd_index_o (gshare_rd_index),
		.gshare_wr_index_o (gshare_wr_index),
		.pred_ghr_o        (pred_ghr_o)
	);

	btb u_btb (
		.clk         (clk),
		.rst_i       (rst_i),
		.lookup_i    (lookup_i),
		.lookup_pc_i (lookup_addr),
		.upd         (upd_if.trainer),
		.hit_o       (btb_hit),
		.target_o    (btb_target)
	);

	tournament_chooser u_tournament_chooser (
		.clk            (clk),
		.rst_i          (rst_i),
		.lookup_i       (lookup_i),
		.lookup_pc_i    (lookup_addr),
		.upd            (upd_if.trainer),
		.local_ctr_i    (local_ctr),
		.gshare_ctr_i   (gshare_ctr),
		.btb_hit_i      (btb_hit),
		.btb_target_i   (btb_target),
		.pred_valid_o   (pred_valid_o),
		.pred_taken_o   (pred_taken_o),
		.pred_next_pc_o (pred_next_pc_o),
		.pred_gshare_o  (pred_gshare_o)
	);

endmodule

// ==== logic/tournament_chooser.sv ====
`timescale 1ns/1ps

module tournament_chooser import rv32_pkg::*, bp_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 lookup_i,
	input  fetch_addr_u          lookup_pc_i,
	bp_update_if.trainer         upd,
	input  logic [CTR_BITS-1:0]  local_ctr_i,
	input  logic [CTR_BITS-1:0]  gshare_ctr_i,
	input  logic                 btb_hit_i,
	input  logic [WORD_BITS-1:0] btb_target_i,
	output logic                 pred_valid_o,
	output logic                 pred_taken_o,
	output logic [WORD_BITS-1:0] pred_next_pc_o,
	output logic                 pred_gshare_o
);

	// MSB set selects gshare
	logic [CTR_BITS-1:0]  choice_table_q [PHT_ENTRIES];

	logic                 valid_q;
	logic                 use_gshare_q;
	logic [WORD_BITS-1:0] pc_q;

	logic                 toward_gshare;
	logic [CTR_BITS-1:0]  sel_ctr;

	// a right guess rewards the used component and a wrong one the other
	assign toward_gshare = (upd.pred_taken == upd.taken) ? upd.used_gshare
		: !upd.used_gshare;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				choice_table_q[i] <= CTR_RESET;
			end
		end else if (upd.valid) begin
			choice_table_q[upd.pc.tbl.index] <=
				ctr_step(choice_table_q[upd.pc.tbl.index], toward_gshare);
		end
	end

	// result of each lookup comes in the next cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= lookup_i;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_i) begin
			use_gshare_q <= choice_table_q[lookup_pc_i.tbl.index][CTR_BITS-1];
			pc_q         <= lookup_pc_i;
		end
	end

	// no BTB target means no taken prediction
	assign sel_ctr      = use_gshare_q ? gshare_ctr_i : local_ctr_i;
	assign pred_taken_o = sel_ctr[CTR_BITS-1] && btb_hit_i;

	assign pred_next_pc_o = pred_taken_o ? btb_target_i
		: pc_q + WORD_BITS'(INST_BYTES);

	assign pred_valid_o  = valid_q;
	assign pred_gshare_o = use_gshare_q;

endmodule

// ==== logic/btb.sv ====
`timescale 1ns/1ps

module btb import rv32_pkg::*, bp_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 lookup_i,
	input  fetch_addr_u          lookup_pc_i,
	bp_update_if.trainer         upd,
	output logic                 hit_o,
	output logic [WORD_BITS-1:0] target_o
);

	logic [BTB_ENTRIES-1:0]  valid_q;
	logic [BTB_TAG_BITS-1:0] tag_q [BTB_ENTRIES];
	logic [WORD_BITS-1:0]    target_q [BTB_ENTRIES];

	// lookup stage
	logic                    rd_valid_q;
	logic [BTB_TAG_BITS-1:0] rd_tag_q;
	logic [BTB_TAG_BITS-1:0] lookup_tag_q;
	logic [WORD_BITS-1:0]    rd_target_q;

	logic                    wr_en;

	// only taken branches get an entry
	assign wr_en = upd.valid && upd.taken;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[upd.pc.btb.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[upd.pc.btb.index]    <= upd.pc.btb.tag;
			target_q[upd.pc.btb.index] <= upd.target;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_valid_q <= 1'b0;
		end else if (lookup_i) begin
			rd_valid_q <= valid_q[lookup_pc_i.btb.index];
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_i) begin
			rd_tag_q     <= tag_q[lookup_pc_i.btb.index];
			rd_target_q  <= target_q[lookup_pc_i.btb.index];
			lookup_tag_q <= lookup_pc_i.btb.tag;
		end
	end

	// tag compare after the registered read
	assign hit_o    = rd_valid_q && (rd_tag_q == lookup_tag_q);
	assign target_o = rd_target_q;

	// fetch never presents a misaligned pc
	a_lookup_aligned: assert property (
		@(posedge clk) disable iff (rst_i)
		lookup_i |-> (lookup_pc_i.btb.offset == '0)
	);

endmodule

// ==== logic/global_history.sv ====
`timescale 1ns/1ps

module global_history import rv32_pkg::*, bp_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      lookup_i,
	input  fetch_addr_u               lookup_pc_i,
	bp_update_if.trainer              upd,
	output logic [PHT_INDEX_BITS-1:0] gshare_rd_index_o,
	output logic [PHT_INDEX_BITS-1:0] gshare_wr_index_o,
	output logic [GHR_BITS-1:0]       pred_ghr_o
);

	logic [GHR_BITS-1:0] ghr_q;
	logic [GHR_BITS-1:0] ghr_snap_q;

	// newest outcome enters at the LSB
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ghr_q <= '0;
		end else if (upd.valid) begin
			ghr_q <= {ghr_q[GHR_BITS-2:0], upd.taken};
		end
	end

	// history seen by this lookup, returned later with the resolve
	always_ff @(posedge clk) begin
		if (lookup_i) begin
			ghr_snap_q <= ghr_q;
		end
	end

	// gshare hash, read side from live history
	assign gshare_rd_index_o = ghr_q ^ lookup_pc_i.tbl.index;

	// write side uses the snapshot so it hits the entry that was read
	assign gshare_wr_index_o = upd.ghr ^ upd.pc.tbl.index;

	assign pred_ghr_o = ghr_snap_q;

endmodule

// ==== logic/pht.sv ====
`timescale 1ns/1ps

module pht import bp_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      rd_en_i,
	input  logic [PHT_INDEX_BITS-1:0] rd_index_i,
	input  logic [PHT_INDEX_BITS-1:0] wr_index_i,
	bp_update_if.trainer              upd,
	output logic [CTR_BITS-1:0]       ctr_o
);

	logic [CTR_BITS-1:0] ctr_table_q [PHT_ENTRIES];
	logic [CTR_BITS-1:0] ctr_q;

	// training on the resolve strobe
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				ctr_table_q[i] <= CTR_RESET;
			end
		end else if (upd.valid) begin
			ctr_table_q[wr_index_i] <= ctr_step(ctr_table_q[wr_index_i], upd.taken);
		end
	end

	// registered read, sees the table before a same-edge update
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			ctr_q <= ctr_table_q[rd_index_i];
		end
	end

	assign ctr_o = ctr_q;

	// strongly taken must not wrap back to strongly not taken
	a_ctr_no_wrap: assert property (
		@(posedge clk) disable iff (rst_i)
		upd.valid && upd.taken && (ctr_table_q[wr_index_i] == CTR_MAX)
		|=> ctr_table_q[$past(wr_index_i)] == CTR_MAX
	);

endmodule

// ==== logic/bp_update_if.sv ====
`timescale 1ns/1ps

interface bp_update_if import rv32_pkg::*, bp_pkg::*; ();

	// resolve strobe, all fields below are sampled only with it
	logic                 valid;
	fetch_addr_u          pc;
	logic                 taken;
	logic [WORD_BITS-1:0] target;

	// snapshot returned from the lookup of this branch
	logic [GHR_BITS-1:0]  ghr;
	logic                 used_gshare;
	logic                 pred_taken;

	// every training block only listens
	modport trainer (
		input valid,
		input pc,
		input taken,
		input target,
		input ghr,
		input used_gshare,
		input pred_taken
	);

endinterface

// ==== logic/rv32_pkg.sv ====
package rv32_pkg;

	// data and address width
	localparam int WORD_BITS = 32;

	// instructions are one word, always word aligned
	localparam int INST_BYTES  = 4;
	localparam int OFFSET_BITS = 2;

	// one fetch address, split for the BTB or for the counter tables
	typedef union packed {
		struct packed {
			logic [bp_pkg::BTB_TAG_BITS-1:0]   tag;
			logic [bp_pkg::BTB_INDEX_BITS-1:0] index;
			logic [OFFSET_BITS-1:0]            offset;
		} btb;
		struct packed {
			logic [WORD_BITS-bp_pkg::PHT_INDEX_BITS-OFFSET_BITS-1:0] upper;
			logic [bp_pkg::PHT_INDEX_BITS-1:0]                       index;
			logic [OFFSET_BITS-1:0]                                  offset;
		} tbl;
	} fetch_addr_u;

endpackage

// ==== logic/bp_pkg.sv ====
package bp_pkg;

	// history length, same as the table index width for gshare
	localparam int GHR_BITS       = 10;
	localparam int PHT_INDEX_BITS = 10;
	localparam int PHT_ENTRIES    = 1 << PHT_INDEX_BITS;

	// branch target buffer geometry
	localparam int BTB_INDEX_BITS = 6;
	localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
	localparam int BTB_TAG_BITS   = 24;

	// 2-bit counters, MSB is the decision
	// tables: weakly not taken, chooser: weakly local
	localparam int                  CTR_BITS  = 2;
	localparam logic [CTR_BITS-1:0] CTR_RESET = CTR_BITS'(1);
	localparam logic [CTR_BITS-1:0] CTR_MAX   = CTR_BITS'(3);

	// one saturating step up or down
	function automatic logic [CTR_BITS-1:0] ctr_step(
		input logic [CTR_BITS-1:0] ctr,
		input logic                up
	);
		if (up) begin
			return (ctr == CTR_MAX) ? ctr : ctr + 1'b1;
		end
		return (ctr == '0) ? ctr : ctr - 1'b1;
	endfunction

endpackage
